//--- verilog/spectrum_mem_pkg.sv
// Bus cycle and RAM request structs, machine model enum, 1FFD register views, map widths
`default_nettype none

package spectrum_mem_pkg;

	// ====================
	// Widths
	// ====================
	localparam int RAM_ADDR_W    = 25;
	localparam int BANK_OFFSET_W = 14;
	localparam int ROM_PAGE_W    = 4;

	// One Z80 bus cycle, all strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	// Request to the external RAM, one per clock
	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic [7:0]            din;
		logic                  we;
		logic                  rd;
	} ram_req_t;

	// Unlisted codes run as a 128K machine
	typedef enum logic [2:0] {
		MACHINE_128K  = 3'd0,
		MACHINE_P512  = 3'd1,
		MACHINE_48K   = 3'd3,
		MACHINE_PLUS3 = 3'd4
	} machine_t;

	// ====================
	// Port 1FFD
	// ====================
	typedef struct packed {
		logic [2:0] spare;
		logic       strobe;
		logic       motor;
		logic       rom_hi;
		logic       unused;
		logic       special;
	} port_1ffd_normal_t;

	// Bit 0 set turns the whole 64K into RAM
	typedef struct packed {
		logic [4:0] rest;
		logic [1:0] bank_config;
		logic       special;
	} port_1ffd_special_t;

	typedef union packed {
		port_1ffd_normal_t  normal;
		port_1ffd_special_t special;
	} port_1ffd_t;

	// Everything the mapper needs to place an access
	typedef struct packed {
		logic [7:0] page_7ffd;
		port_1ffd_t page_1ffd;
		logic [2:0] bank_hi;
		logic       is_48k;
		logic       is_plus3;
	} page_state_t;

endpackage

`default_nettype wire

//--- verilog/bus_cycle_control.sv
// Port write decode with edge detection and CPU read data select
`timescale 1ns/1ns
`default_nettype none

module bus_cycle_control import spectrum_mem_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  cpu_bus_t        cpu,
	input  wire logic       locked,
	input  wire logic       is_plus3,
	input  wire logic [7:0] ram_dout,
	input  wire logic [7:0] fe_dout,
	output logic            wr_7ffd,
	output logic            wr_1ffd,
	output logic            wr_fe,
	output logic [7:0]      cpu_din
);

	logic io_wr;
	logic io_rd;
	logic io_wr_prev;
	logic io_wr_start;
	logic mem_rd;
	logic hit_7ffd;
	logic hit_1ffd;
	logic hit_fe;

	// ====================
	// Cycle qualify
	// ====================
	// Interrupt acknowledge has iorq with m1, so keep it out
	assign io_wr  = cpu.iorq & cpu.wr & ~cpu.m1;
	assign io_rd  = cpu.iorq & cpu.rd & ~cpu.m1;
	assign mem_rd = cpu.mreq & cpu.rd;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_prev <= 1'b0;
		end else begin
			io_wr_prev <= io_wr;
		end
	end

	// A long write level counts only on its first cycle
	assign io_wr_start = io_wr & ~io_wr_prev;

	// ====================
	// Port decode
	// ====================
	// 7FFD on +3 also needs A14 high so it does not alias 1FFD
	assign hit_7ffd = ~cpu.addr[15] & ~cpu.addr[1] & (cpu.addr[14] | ~is_plus3) & ~locked;
	assign hit_1ffd = (cpu.addr[15:13] == 3'b000) & cpu.addr[12] & ~cpu.addr[1] & is_plus3
		& ~locked;
	assign hit_fe   = ~cpu.addr[0];

	assign wr_7ffd = io_wr_start & hit_7ffd;
	assign wr_1ffd = io_wr_start & hit_1ffd;

	// Paging ports win over the ULA when a sloppy address hits both
	assign wr_fe = io_wr_start & hit_fe & ~hit_7ffd & ~hit_1ffd;

	// ====================
	// Read data
	// ====================
	always_comb begin
		if (mem_rd) begin
			cpu_din = ram_dout;
		end else if (io_rd & ~cpu.addr[0]) begin
			cpu_din = fe_dout;
		end else begin
			// Floating bus
			cpu_din = 8'hFF;
		end
	end

endmodule

`default_nettype wire

//--- verilog/paging_registers.sv
// 7FFD, 1FFD and Pentagon high bank registers, paging lock and machine model flags
`timescale 1ns/1ns
`default_nettype none

module paging_registers import spectrum_mem_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  machine_t        model,
	input  wire logic [7:0] data,
	input  wire logic       wr_7ffd,
	input  wire logic       wr_1ffd,
	output page_state_t     page,
	output logic            locked,
	output logic            screen_page
);

	logic is_p512;

	// ====================
	// Registers
	// ====================
	// Model flags follow the model input for as long as reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page.page_7ffd <= '0;
			page.page_1ffd <= '0;
			page.bank_hi   <= '0;
			page.is_48k    <= (model == MACHINE_48K);
			page.is_plus3  <= (model == MACHINE_PLUS3);
			is_p512        <= (model == MACHINE_P512);
		end else begin
			if (wr_7ffd) begin
				page.page_7ffd <= data;
				// Pentagon 512 uses the two top bits as extra bank select
				if (is_p512) begin
					page.bank_hi[1:0] <= data[7:6];
				end
			end
			if (wr_1ffd) begin
				page.page_1ffd <= data;
			end
		end
	end

	// ====================
	// Derived outputs
	// ====================
	// Bit 5 locks paging until the next reset; 48K never pages
	assign locked = page.is_48k | page.page_7ffd[5];

	// Shadow screen in bank 7 when set
	assign screen_page = page.page_7ffd[3];

endmodule

`default_nettype wire

//--- verilog/memory_mapper.sv
// CPU address to external RAM address mapping, ROM page select and RAM strobes
`timescale 1ns/1ns
`default_nettype none

module memory_mapper import spectrum_mem_pkg::*; (
	input  cpu_bus_t    cpu,
	input  page_state_t page,
	output ram_req_t    ram
);

	logic [1:0]               slot;
	logic [BANK_OFFSET_W-1:0] offset;
	logic                     special_mode;
	logic [1:0]               bank_config;
	logic [ROM_PAGE_W-1:0]    rom_page;
	logic [5:0]               ram_bank;
	logic                     rom_sel;

	assign slot         = cpu.addr[15:14];
	assign offset       = cpu.addr[BANK_OFFSET_W-1:0];
	assign special_mode = page.page_1ffd.special.special;
	assign bank_config  = page.page_1ffd.special.bank_config;

	// ====================
	// ROM page
	// ====================
	always_comb begin
		if (page.is_plus3) begin
			// Four +3 ROMs, two select bits from two ports
			rom_page = {2'b10, page.page_1ffd.normal.rom_hi, page.page_7ffd[4]};
		end else begin
			rom_page = {3'b011, page.is_48k | page.page_7ffd[4]};
		end
	end

	// ====================
	// Bank select
	// ====================
	always_comb begin
		rom_sel  = 1'b0;
		ram_bank = '0;
		if (special_mode) begin
			// All-RAM layouts of the +3, bank per slot 0..3
			case ({bank_config, slot})
				4'b00_00: ram_bank = 6'd0;
				4'b00_01: ram_bank = 6'd1;
				4'b00_10: ram_bank = 6'd2;
				4'b00_11: ram_bank = 6'd3;
				4'b01_00: ram_bank = 6'd4;
				4'b01_01: ram_bank = 6'd5;
				4'b01_10: ram_bank = 6'd6;
				4'b01_11: ram_bank = 6'd7;
				4'b10_00: ram_bank = 6'd4;
				4'b10_01: ram_bank = 6'd5;
				4'b10_10: ram_bank = 6'd6;
				4'b10_11: ram_bank = 6'd3;
				4'b11_00: ram_bank = 6'd4;
				4'b11_01: ram_bank = 6'd7;
				4'b11_10: ram_bank = 6'd6;
				default:  ram_bank = 6'd3;
			endcase
		end else begin
			case (slot)
				2'd0: rom_sel = 1'b1;
				2'd1: ram_bank = 6'd5;
				2'd2: ram_bank = 6'd2;
				default: ram_bank = {page.bank_hi, page.page_7ffd[2:0]};
			endcase
		end
	end

	// ====================
	// RAM request
	// ====================
	always_comb begin
		if (rom_sel) begin
			// ROM images sit above the RAM banks
			ram.addr = RAM_ADDR_W'({3'b101, rom_page, offset});
		end else begin
			ram.addr = RAM_ADDR_W'({ram_bank, offset});
		end
		ram.din = cpu.dout;
		ram.rd  = cpu.mreq & cpu.rd;
		// Slot 0 is write protected unless it holds RAM
		ram.we  = cpu.mreq & cpu.wr & (special_mode | cpu.addr[15] | cpu.addr[14]);
	end

endmodule

`default_nettype wire

//--- verilog/ula_port.sv
// ULA port FE latch for border, ear and mic, and the FE read value
`timescale 1ns/1ns
`default_nettype none

module ula_port (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire logic [7:0] data,
	input  wire logic       wr_fe,
	input  wire logic       tape_in,
	input  wire logic [4:0] key_data,
	output logic [7:0]      fe_dout,
	output logic [2:0]      border_color,
	output logic            ear_out,
	output logic            mic_out
);

	// Border colour is only a display value
	always_ff @(posedge clk_sys) begin
		if (wr_fe) begin
			border_color <= data[2:0];
		end
	end

	// Speaker and tape out must be quiet after reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (wr_fe) begin
			ear_out <= data[4];
			mic_out <= data[3];
		end
	end

	// Keyboard half-row, active low, with tape level in bit 6
	assign fe_dout = {1'b1, ~tape_in, 1'b1, key_data};

endmodule

`default_nettype wire

//--- verilog/spectrum_mem_io.sv
// Top level of the paging and port I/O core
`timescale 1ns/1ns
`default_nettype none

module spectrum_mem_io import spectrum_mem_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  cpu_bus_t        cpu,
	input  machine_t        model,
	input  wire logic [7:0] ram_dout,
	input  wire logic [4:0] key_data,
	input  wire logic       tape_in,
	output ram_req_t        ram,
	output logic [7:0]      cpu_din,
	output logic [2:0]      border_color,
	output logic            ear_out,
	output logic            mic_out,
	output logic            screen_page
);

	logic        wr_7ffd;
	logic        wr_1ffd;
	logic        wr_fe;
	logic        locked;
	logic [7:0]  fe_dout;
	page_state_t page;

	bus_cycle_control u_bus_cycle_control (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu      (cpu),
		.locked   (locked),
		.is_plus3 (page.is_plus3),
		.ram_dout (ram_dout),
		.fe_dout  (fe_dout),
		.wr_7ffd  (wr_7ffd),
		.wr_1ffd  (wr_1ffd),
		.wr_fe    (wr_fe),
		.cpu_din  (cpu_din)
	);

	paging_registers u_paging_registers (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.model       (model),
		.data        (cpu.dout),
		.wr_7ffd     (wr_7ffd),
		.wr_1ffd     (wr_1ffd),
		.page        (page),
		.locked      (locked),
		.screen_page (screen_page)
	);

	memory_mapper u_memory_mapper (
		.cpu  (cpu),
		.page (page),
		.ram  (ram)
	);

	ula_port u_ula_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.data         (cpu.dout),
		.wr_fe        (wr_fe),
		.tape_in      (tape_in),
		.key_data     (key_data),
		.fe_dout      (fe_dout),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

endmodule

`default_nettype wire

//--- tests/spectrum_mem_io_assertions.sv
// Concurrent checks on the paging lock and the paging port write pulses
`timescale 1ns/1ns
`default_nettype none

module spectrum_mem_io_assertions import spectrum_mem_pkg::*; (
	input wire logic  clk_sys,
	input wire logic  reset,
	input wire logic  wr_7ffd,
	input wire logic  wr_1ffd,
	input page_state_t page,
	input wire logic  locked
);

	// Once locked, 7FFD stays frozen until the next reset
	property lock_holds_7ffd;
		@(posedge clk_sys) disable iff (reset)
		locked |=> $stable(page.page_7ffd);
	endproperty

	property one_pulse_per_cycle;
		@(posedge clk_sys) disable iff (reset)
		$onehot0({wr_7ffd, wr_1ffd});
	endproperty

	lock_check: assert property (lock_holds_7ffd)
		else $error("7FFD changed while paging was locked");
	pulse_check: assert property (one_pulse_per_cycle)
		else $error("More than one paging write pulse in one cycle");

endmodule

bind paging_registers spectrum_mem_io_assertions u_assertions (
	.clk_sys (clk_sys),
	.reset   (reset),
	.wr_7ffd (wr_7ffd),
	.wr_1ffd (wr_1ffd),
	.page    (page),
	.locked  (locked)
);

`default_nettype wire

//--- tests/spectrum_mem_io_tb.sv
// Testbench with paging reference model, per-cycle compare, stimulus and watchdog
`timescale 1ns/1ns
`default_nettype none

module spectrum_mem_io_tb import spectrum_mem_pkg::*;;

	localparam int CLK_PERIOD  = 20;
	localparam int RESET_LEN   = 4;
	localparam int ROUNDS      = 12;
	localparam int ACCESSES    = 10;
	localparam int TEST_CYCLES = 6 * (RESET_LEN + 1) + 5 * ROUNDS * (ACCESSES + 4);
	localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * CLK_PERIOD;

	logic       clk_sys = 1'b0;
	logic       reset;
	cpu_bus_t   cpu;
	machine_t   model;
	logic [7:0] ram_dout;
	logic [4:0] key_data;
	logic       tape_in;
	ram_req_t   ram;
	logic [7:0] cpu_din;
	logic [2:0] border_color;
	logic       ear_out;
	logic       mic_out;
	logic       screen_page;

	// Reference copy of the paging and ULA state
	logic [7:0] m_7ffd;
	logic [7:0] m_1ffd;
	logic [2:0] m_bank_hi;
	logic       m_48k;
	logic       m_plus3;
	logic       m_p512;
	logic       m_prev_wr;
	logic [2:0] m_border;
	logic       m_ear;
	logic       m_mic;
	logic       border_known;
	ram_req_t   exp_ram;

	spectrum_mem_io DUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu          (cpu),
		.model        (model),
		.ram_dout     (ram_dout),
		.key_data     (key_data),
		.tape_in      (tape_in),
		.ram          (ram),
		.cpu_din      (cpu_din),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out),
		.screen_page  (screen_page)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("TEST FAILED");
		$fatal(1, "Watchdog expired before the stimulus finished");
	end

	// ====================
	// Reference model
	// ====================
	// Bank per slot in +3 special mode, slot 3 in the top field
	function automatic logic [5:0] special_bank(input logic [1:0] cfg, input logic [1:0] slot);
		logic [11:0] layout;
		case (cfg)
			2'd0: layout = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1: layout = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2: layout = {3'd3, 3'd6, 3'd5, 3'd4};
			default: layout = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
		return {3'd0, layout[int'(slot) * 3 +: 3]};
	endfunction

	function automatic ram_req_t expected_ram(input cpu_bus_t c);
		ram_req_t   r;
		logic [1:0] slot;
		logic [3:0] rom;
		logic [5:0] bank;
		slot = c.addr[15:14];
		if (m_plus3) begin
			rom = {2'b10, m_1ffd[2], m_7ffd[4]};
		end else begin
			rom = {3'b011, m_48k | m_7ffd[4]};
		end
		case (slot)
			2'd1: bank = 6'd5;
			2'd2: bank = 6'd2;
			default: bank = {m_bank_hi, m_7ffd[2:0]};
		endcase
		if (m_1ffd[0]) begin
			r.addr = {5'd0, special_bank(m_1ffd[2:1], slot), c.addr[13:0]};
		end else if (slot == 2'd0) begin
			r.addr = {4'd0, 3'b101, rom, c.addr[13:0]};
		end else begin
			r.addr = {5'd0, bank, c.addr[13:0]};
		end
		r.din = c.dout;
		r.rd  = c.mreq & c.rd;
		r.we  = c.mreq & c.wr & (m_1ffd[0] | (slot != 2'd0));
		return r;
	endfunction

	function automatic logic [7:0] expected_din(input cpu_bus_t c);
		if (c.mreq & c.rd) begin
			return ram_dout;
		end
		if (c.iorq & c.rd & ~c.m1 & ~c.addr[0]) begin
			return {1'b1, ~tape_in, 1'b1, key_data};
		end
		return 8'hFF;
	endfunction

	task automatic reset_model();
		m_7ffd    = '0;
		m_1ffd    = '0;
		m_bank_hi = '0;
		m_48k     = (model == MACHINE_48K);
		m_plus3   = (model == MACHINE_PLUS3);
		m_p512    = (model == MACHINE_P512);
		m_prev_wr = 1'b0;
		m_ear     = 1'b0;
		m_mic     = 1'b0;
	endtask

	// Applies the port write that the next rising edge will latch
	task automatic update_model(input cpu_bus_t c);
		logic io_wr;
		logic locked;
		io_wr  = c.iorq & c.wr & ~c.m1;
		locked = m_48k | m_7ffd[5];
		if (io_wr & ~m_prev_wr) begin
			if (!c.addr[15] && !c.addr[1] && (c.addr[14] || !m_plus3) && !locked) begin
				m_7ffd = c.dout;
				if (m_p512) begin
					m_bank_hi[1:0] = c.dout[7:6];
				end
			end else if (c.addr[15:12] == 4'b0001 && !c.addr[1] && m_plus3 && !locked) begin
				m_1ffd = c.dout;
			end else if (!c.addr[0]) begin
				m_border     = c.dout[2:0];
				m_ear        = c.dout[4];
				m_mic        = c.dout[3];
				border_known = 1'b1;
			end
		end
		m_prev_wr = io_wr;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, expected);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clk_sys) begin
		if (reset) begin
			reset_model();
		end else begin
			exp_ram = expected_ram(cpu);
			check_value("ram.addr", 32'(ram.addr), 32'(exp_ram.addr));
			check_value("ram.we", 32'(ram.we), 32'(exp_ram.we));
			check_value("ram.rd", 32'(ram.rd), 32'(exp_ram.rd));
			check_value("ram.din", 32'(ram.din), 32'(exp_ram.din));
			check_value("cpu_din", 32'(cpu_din), 32'(expected_din(cpu)));
			check_value("screen_page", 32'(screen_page), 32'(m_7ffd[3]));
			check_value("ear_out", 32'(ear_out), 32'(m_ear));
			check_value("mic_out", 32'(mic_out), 32'(m_mic));
			if (border_known) begin
				check_value("border_color", 32'(border_color), 32'(m_border));
			end
			update_model(cpu);
		end
	end

	// ====================
	// Stimulus
	// ====================
	function automatic cpu_bus_t make_cycle(input logic [15:0] addr, input logic [7:0] dout,
		input logic mreq, input logic iorq, input logic rd, input logic wr);
		cpu_bus_t c;
		c.addr = addr;
		c.dout = dout;
		c.mreq = mreq;
		c.iorq = iorq;
		c.rd   = rd;
		c.wr   = wr;
		c.m1   = 1'b0;
		return c;
	endfunction

	task automatic drive(input cpu_bus_t c);
		@(posedge clk_sys);
		cpu      <= c;
		ram_dout <= 8'($urandom);
		key_data <= 5'($urandom);
		tape_in  <= 1'($urandom);
	endtask

	task automatic apply_reset(input machine_t m);
		@(posedge clk_sys);
		reset <= 1'b1;
		model <= m;
		cpu   <= make_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
		repeat (RESET_LEN) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	// Write level held one or two cycles, then released
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		int hold;
		hold = 1 + int'($urandom_range(1, 0));
		repeat (hold) drive(make_cycle(addr, data, 1'b0, 1'b1, 1'b0, 1'b1));
		drive(make_cycle(addr, data, 1'b0, 1'b0, 1'b0, 1'b0));
	endtask

	task automatic io_read(input logic [15:0] addr);
		drive(make_cycle(addr, 8'hFF, 1'b0, 1'b1, 1'b1, 1'b0));
	endtask

	task automatic mem_access(input logic [15:0] addr, input logic [7:0] data, input logic write);
		drive(make_cycle(addr, data, 1'b1, 1'b0, ~write, write));
	endtask

	initial begin
		logic [7:0] data;
		void'($urandom(32'h14257b61));
		reset        = 1'b1;
		cpu          = make_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
		model        = MACHINE_128K;
		ram_dout     = 8'h00;
		key_data     = 5'h1F;
		tape_in      = 1'b0;
		border_known = 1'b0;

		// 128K paging with random bank selects
		apply_reset(MACHINE_128K);
		repeat (ROUNDS) begin
			data    = 8'($urandom);
			data[5] = 1'b0;
			io_write(16'h7FFD, data);
			repeat (ACCESSES) mem_access(16'($urandom), 8'($urandom), 1'($urandom));
		end

		// Lock bit, then a 48K machine that never pages
		io_write(16'h7FFD, 8'h27);
		repeat (4) io_write(16'h7FFD, 8'($urandom));
		repeat (ACCESSES) mem_access(16'($urandom), 8'($urandom), 1'($urandom));
		apply_reset(MACHINE_48K);
		repeat (4) io_write(16'h7FFD, 8'($urandom) & 8'hDF);
		repeat (ACCESSES) mem_access(16'($urandom), 8'($urandom), 1'($urandom));

		// +3 special layouts, then ROM select in normal mode
		apply_reset(MACHINE_PLUS3);
		for (int cfg = 0; cfg < 4; cfg++) begin
			io_write(16'h1FFD, {5'($urandom), 2'(cfg), 1'b1});
			for (int slot = 0; slot < 4; slot++) begin
				repeat (2) mem_access({2'(slot), 14'($urandom)}, 8'($urandom), 1'($urandom));
			end
		end
		for (int sel = 0; sel < 4; sel++) begin
			data    = 8'($urandom);
			data[0] = 1'b0;
			data[2] = sel[1];
			io_write(16'h1FFD, data);
			data    = 8'($urandom);
			data[5] = 1'b0;
			data[4] = sel[0];
			io_write(16'h7FFD, data);
			repeat (4) mem_access({2'b00, 14'($urandom)}, 8'($urandom), 1'($urandom));
		end

		// Pentagon 512 high bank bits in slot 3
		apply_reset(MACHINE_P512);
		repeat (ROUNDS) begin
			data    = 8'($urandom);
			data[5] = 1'b0;
			io_write(16'h7FFD, data);
			repeat (ACCESSES) mem_access({2'b11, 14'($urandom)}, 8'($urandom), 1'($urandom));
		end

		// ULA port writes and the read data paths
		apply_reset(MACHINE_128K);
		repeat (ROUNDS) begin
			io_write({8'($urandom), 8'hFE}, 8'($urandom));
			io_read({8'($urandom), 8'hFE});
			io_read({15'($urandom), 1'b1});
			mem_access(16'($urandom), 8'($urandom), 1'b0);
		end

		drive(make_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0));
		repeat (2) @(posedge clk_sys);
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- spectrum_mem_io.f
verilog/spectrum_mem_pkg.sv
verilog/bus_cycle_control.sv
verilog/paging_registers.sv
verilog/memory_mapper.sv
verilog/ula_port.sv
verilog/spectrum_mem_io.sv
tests/spectrum_mem_io_assertions.sv
tests/spectrum_mem_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the paging core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module spectrum_mem_io_tb \
	-f spectrum_mem_io.f \
	-o sim_spectrum_mem_io

./obj_dir/sim_spectrum_mem_io
